// ==== include/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// pmp region bounds, byte addresses
`define CSR_PMP_BIOS_BASE   32'h0000_0000
`define CSR_PMP_RAM_BASE    32'h1000_0000
`define CSR_PMP_VRAM_BASE   32'h2000_0000
`define CSR_PMP_REGION_SIZE 32'h0000_1000

// memory mapped device words
`define CSR_PMP_SEG_ADDR    32'hFF00_0004  // seven segment display
`define CSR_PMP_SW_ADDR     32'hFF00_0008  // switch bank

// machine identification
`define CSR_MISA_VALUE      32'h4000_0100  // mxl=1, base isa I
`define CSR_MIMPID_VALUE    32'h0000_0001

// width of cycle, time and instret
`define CSR_CNT_WIDTH       64

`endif

// ==== hw/csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`CSR_CNT_WIDTH-1:0] dword_t;

    // implemented csr addresses only
    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MIP           = 12'h344,
        CSR_PMPCFG0       = 12'h3A0,
        CSR_PMPCFG1       = 12'h3A1,
        CSR_PMPCFG2       = 12'h3A2,
        CSR_PMPADDR0      = 12'h3B0,
        CSR_PMPADDR1      = 12'h3B1,
        CSR_PMPADDR2      = 12'h3B2,
        CSR_PMPADDR3      = 12'h3B3,
        CSR_PMPADDR4      = 12'h3B4,
        CSR_PMPADDR5      = 12'h3B5,
        CSR_PMPADDR6      = 12'h3B6,
        CSR_PMPADDR7      = 12'h3B7,
        CSR_PMPADDR8      = 12'h3B8,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,
        CSR_TIME          = 12'hC01,
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_TIMEH         = 12'hC81,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_e;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'd0,
        PMP_TOR   = 2'd1,
        PMP_NA4   = 2'd2,
        PMP_NAPOT = 2'd3
    } pmp_mode_e;

    typedef struct packed {
        logic [29:0] base;
        mtvec_mode_e mode;
    } mtvec_t;

    typedef struct packed {
        logic [23:0] rsvd_31_8;
        logic        mpie;        // bit 7
        logic [2:0]  rsvd_6_4;
        logic        mie;         // bit 3
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    typedef struct packed {
        logic        is_interrupt;
        logic [30:0] code;
    } mcause_t;

    // layout shared by mie and mip
    typedef struct packed {
        logic [3:0] rsvd_15_12;
        logic       mei;          // bit 11
        logic [2:0] rsvd_10_8;
        logic       mti;          // bit 7
        logic [2:0] rsvd_6_4;
        logic       msi;          // bit 3
        logic [2:0] rsvd_2_0;
    } mi_t;

    typedef struct packed {
        logic       locked;
        logic [1:0] rsvd;
        pmp_mode_e  mode;
        logic [2:0] rwx;          // x at bit 2, r at bit 0
    } pmp_cfg_t;

    typedef struct packed {
        word_t    addr;           // byte address >> 2
        pmp_cfg_t cfg;
    } pmp_entry_t;

    typedef struct packed {
        csr_addr_e addr;
        word_t     data;
        logic      en;
    } csr_wr_t;

    typedef struct packed {
        word_t   trap_pc;
        mcause_t cause;
        logic    mtrap;
        logic    mret;
    } trap_req_t;

    localparam logic [30:0] INT_M_EXTERNAL = 31'd11;

    localparam logic [2:0] PMP_NONE = 3'b000;
    localparam logic [2:0] PMP_R    = 3'b001;
    localparam logic [2:0] PMP_W    = 3'b010;
    localparam logic [2:0] PMP_X    = 3'b100;

    function automatic pmp_entry_t pmp_entry(word_t byte_addr, pmp_mode_e amode,
                                             logic [2:0] perm);
        pmp_entry_t e;
        e.addr = byte_addr >> 2;
        e.cfg  = '{locked: 1'b1, rsvd: 2'b00, mode: amode, rwx: perm};
        return e;
    endfunction

    // every entry locked, the table never changes
    localparam pmp_entry_t [0:8] PMP_TABLE = '{
        pmp_entry(`CSR_PMP_BIOS_BASE, PMP_NAPOT, PMP_R | PMP_X),
        pmp_entry(`CSR_PMP_BIOS_BASE + `CSR_PMP_REGION_SIZE, PMP_OFF, PMP_NONE),
        pmp_entry(`CSR_PMP_RAM_BASE, PMP_NAPOT, PMP_R | PMP_W),
        pmp_entry(`CSR_PMP_RAM_BASE + `CSR_PMP_REGION_SIZE, PMP_OFF, PMP_NONE),
        pmp_entry(`CSR_PMP_VRAM_BASE, PMP_NAPOT, PMP_R | PMP_W),
        pmp_entry(`CSR_PMP_VRAM_BASE + `CSR_PMP_REGION_SIZE, PMP_OFF, PMP_NONE),
        pmp_entry(`CSR_PMP_SEG_ADDR, PMP_NA4, PMP_R | PMP_W),
        pmp_entry(`CSR_PMP_SW_ADDR, PMP_NA4, PMP_R),
        pmp_entry(32'hFFFF_FFFF, PMP_TOR, PMP_NONE)   // rest of the space
    };

endpackage

// ==== hw/csr_pmp_lookup.sv ====
`include "csr_cfg.svh"

module csr_pmp_lookup (
    input  csr_pkg::word_t addr_i,   // byte address
    output logic [2:0]     rwx_o
);
    import csr_pkg::*;

    word_t word_addr;

    assign word_addr = {2'b00, addr_i[31:2]};

    // lowest priority first, later hits overwrite
    always_comb begin
        rwx_o = PMP_TABLE[8].cfg.rwx;   // tor tail, no access

        for (int i = 7; i >= 6; i--) begin
            if (word_addr == PMP_TABLE[i].addr) begin
                rwx_o = PMP_TABLE[i].cfg.rwx;   // single device word
            end
        end

        // region i runs up to the next entry's address
        for (int i = 5; i >= 0; i--) begin
            if (word_addr < PMP_TABLE[i+1].addr) begin
                rwx_o = PMP_TABLE[i].cfg.rwx;
            end
        end
    end

    // the strict-below scan only works on an ascending table
    for (genvar i = 0; i < 8; i++) begin : g_order
        if (PMP_TABLE[i].addr >= PMP_TABLE[i+1].addr) begin : g_bad
            $error("PMP_TABLE entry %0d is not below entry %0d", i, i + 1);
        end
    end

endmodule

// ==== hw/csr_counters.sv ====
`include "csr_cfg.svh"

module csr_counters (
    input  logic             clk_i,
    input  logic             reset_i,
    input  csr_pkg::csr_wr_t wr_i,
    input  logic             retired_i,
    input  csr_pkg::word_t   inhibit_i,   // mcountinhibit
    output csr_pkg::dword_t  cycle_o,
    output csr_pkg::dword_t  time_o,
    output csr_pkg::dword_t  instret_o
);
    import csr_pkg::*;

    // index 0 cycle, 1 time, 2 instret, same as the inhibit bits
    dword_t [2:0] cnt_q;
    logic   [2:0] inc;
    logic   [2:0] wr_lo;
    logic   [2:0] wr_hi;

    // a half write replaces that half and skips the increment
    function automatic dword_t next_count(dword_t cnt, logic step, logic lo, logic hi,
                                          word_t data);
        if (lo) begin
            return {cnt[`CSR_CNT_WIDTH-1:32], data};
        end
        if (hi) begin
            return {data, cnt[31:0]};
        end
        return step ? cnt + 1'b1 : cnt;
    endfunction

    assign inc = {retired_i & ~inhibit_i[2], 1'b1, ~inhibit_i[0]};   // time never stops

    always_comb begin
        wr_lo = '0;
        wr_hi = '0;
        if (wr_i.en) begin
            case (wr_i.addr)
                CSR_CYCLE, CSR_MCYCLE:       wr_lo[0] = 1'b1;
                CSR_TIME:                    wr_lo[1] = 1'b1;
                CSR_INSTRET, CSR_MINSTRET:   wr_lo[2] = 1'b1;
                CSR_CYCLEH, CSR_MCYCLEH:     wr_hi[0] = 1'b1;
                CSR_TIMEH:                   wr_hi[1] = 1'b1;
                CSR_INSTRETH, CSR_MINSTRETH: wr_hi[2] = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                cnt_q[i] <= next_count(cnt_q[i], inc[i], wr_lo[i], wr_hi[i], wr_i.data);
            end
        end
    end

    assign cycle_o   = cnt_q[0];
    assign time_o    = cnt_q[1];
    assign instret_o = cnt_q[2];

    time_steps_by_one: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(wr_lo[1] || wr_hi[1]) |=> cnt_q[1] == $past(cnt_q[1]) + 1'b1
    ) else $error("time counter did not advance by one");

endmodule

// ==== hw/csr_trap_ctrl.sv ====
`include "csr_cfg.svh"

module csr_trap_ctrl (
    input  logic               clk_i,
    input  logic               reset_i,
    input  csr_pkg::csr_wr_t   wr_i,
    input  csr_pkg::trap_req_t trap_i,
    input  logic               irq_i,          // external interrupt level
    input  logic               meie_i,
    input  logic               jmp_accept_i,
    output logic               jmp_request_o,
    output csr_pkg::word_t     jmp_addr_o,
    output csr_pkg::mstatus_t  mstatus_o,
    output csr_pkg::mtvec_t    mtvec_o,
    output csr_pkg::word_t     mepc_o,
    output csr_pkg::mcause_t   mcause_o
);
    import csr_pkg::*;

    mstatus_t mstatus_q;
    mtvec_t   mtvec_q;
    word_t    mepc_q;
    mcause_t  mcause_q;

    logic take_ret;     // mret first, then trap, then interrupt
    logic take_trap;
    logic take_irq;
    logic enter;        // accepted trap or interrupt entry
    logic leave;        // accepted mret
    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;

    assign wr_mstatus = wr_i.en && wr_i.addr == CSR_MSTATUS;
    assign wr_mtvec   = wr_i.en && wr_i.addr == CSR_MTVEC;
    assign wr_mepc    = wr_i.en && wr_i.addr == CSR_MEPC;

    assign take_ret  = trap_i.mret;
    assign take_trap = trap_i.mtrap && !trap_i.mret;
    assign take_irq  = irq_i && meie_i && mstatus_q.mie && !trap_i.mtrap && !trap_i.mret;

    assign jmp_request_o = take_ret || take_trap || take_irq;
    assign enter         = jmp_accept_i && (take_trap || take_irq);
    assign leave         = jmp_accept_i && take_ret;

    always_comb begin
        jmp_addr_o = '0;
        if (take_ret) begin
            jmp_addr_o = mepc_q;
        end else if (take_irq && mtvec_q.mode == MTVEC_VECTORED) begin
            jmp_addr_o = {mtvec_q.base + INT_M_EXTERNAL[29:0], 2'b00};   // base + 4*11
        end else if (take_trap || take_irq) begin
            jmp_addr_o = {mtvec_q.base, 2'b00};
        end
    end

    // csr writes win over a trap in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mstatus_q <= '0;
            mtvec_q   <= '{base: '0, mode: MTVEC_DIRECT};
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            if (wr_mtvec) begin
                mtvec_q <= '{base: wr_i.data[31:2],
                             mode: wr_i.data[0] ? MTVEC_VECTORED : MTVEC_DIRECT};
            end

            if (wr_mstatus) begin
                mstatus_q <= '{mie: wr_i.data[3], mpie: wr_i.data[7], default: '0};
            end else if (enter) begin
                mstatus_q <= '{mie: 1'b0, mpie: mstatus_q.mie, default: '0};   // push
            end else if (leave) begin
                mstatus_q <= '{mie: mstatus_q.mpie, mpie: 1'b1, default: '0};  // pop
            end

            if (wr_mepc) begin
                mepc_q <= wr_i.data;
            end else if (enter) begin
                mepc_q <= trap_i.trap_pc;
            end else if (leave) begin
                mepc_q <= '0;
            end

            if (jmp_accept_i && take_trap) begin
                mcause_q <= trap_i.cause;
            end else if (jmp_accept_i && take_irq) begin
                mcause_q <= '{is_interrupt: 1'b1, code: INT_M_EXTERNAL};
            end else if (leave) begin
                mcause_q <= '0;
            end
        end
    end

    assign mstatus_o = mstatus_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mcause_o  = mcause_q;

    // pipeline must never raise a trap and an mret together
    no_trap_with_ret: assert property (
        @(posedge clk_i) disable iff (reset_i)
        jmp_request_o |-> !(trap_i.mtrap && trap_i.mret)
    ) else $error("mtrap and mret requested in the same cycle");

endmodule

// ==== hw/csr_file.sv ====
`include "csr_cfg.svh"

module csr_file (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               retired_i,       // instruction retired this cycle
    input  logic               irq_i,           // external interrupt level
    input  csr_pkg::trap_req_t trap_i,
    output logic               jmp_request_o,
    output csr_pkg::word_t     jmp_addr_o,
    input  logic               jmp_accept_i,
    input  csr_pkg::csr_addr_e read_addr_i,
    input  logic               read_enable_i,
    output csr_pkg::word_t     read_data_o,
    input  csr_pkg::csr_wr_t   wr_i,
    input  csr_pkg::word_t     lookup1_addr_i,
    output logic [2:0]         lookup1_rwx_o,
    input  csr_pkg::word_t     lookup2_addr_i,
    output logic [2:0]         lookup2_rwx_o
);
    import csr_pkg::*;

    word_t    mscratch_q;
    word_t    mcountinhibit_q;
    mi_t      mie_q;
    mi_t      mip;
    word_t    read_data_q;

    dword_t   cycle_cnt;
    dword_t   time_cnt;
    dword_t   instret_cnt;
    mstatus_t mstatus;
    mtvec_t   mtvec;
    word_t    mepc;
    mcause_t  mcause;

    // only the external interrupt is wired up
    assign mip = '{mei: irq_i, default: '0};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mscratch_q      <= '0;
            mcountinhibit_q <= '0;
            mie_q           <= '0;
        end else if (wr_i.en) begin
            case (wr_i.addr)
                CSR_MSCRATCH:      mscratch_q      <= wr_i.data;
                CSR_MCOUNTINHIBIT: mcountinhibit_q <= wr_i.data;
                CSR_MIE: begin
                    mie_q <= '{mei: wr_i.data[11], mti: wr_i.data[7], msi: wr_i.data[3],
                               default: '0};
                end
                default: ;
            endcase
        end
    end

    csr_counters u_counters (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_i      (wr_i),
        .retired_i (retired_i),
        .inhibit_i (mcountinhibit_q),
        .cycle_o   (cycle_cnt),
        .time_o    (time_cnt),
        .instret_o (instret_cnt)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .wr_i          (wr_i),
        .trap_i        (trap_i),
        .irq_i         (irq_i),
        .meie_i        (mie_q.mei),
        .jmp_accept_i  (jmp_accept_i),
        .jmp_request_o (jmp_request_o),
        .jmp_addr_o    (jmp_addr_o),
        .mstatus_o     (mstatus),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc),
        .mcause_o      (mcause)
    );

    csr_pmp_lookup u_lookup1 (
        .addr_i (lookup1_addr_i),
        .rwx_o  (lookup1_rwx_o)
    );

    csr_pmp_lookup u_lookup2 (
        .addr_i (lookup2_addr_i),
        .rwx_o  (lookup2_rwx_o)
    );

    // one cycle read latency, zero when idle
    always_ff @(posedge clk_i) begin
        if (reset_i || !read_enable_i) begin
            read_data_q <= '0;
        end else begin
            case (read_addr_i)
                CSR_MISA:          read_data_q <= `CSR_MISA_VALUE;
                CSR_MIMPID:        read_data_q <= `CSR_MIMPID_VALUE;
                CSR_MVENDORID,
                CSR_MARCHID,
                CSR_MHARTID:       read_data_q <= '0;
                CSR_MSTATUS:       read_data_q <= mstatus;
                CSR_MTVEC:         read_data_q <= mtvec;
                CSR_MEPC:          read_data_q <= mepc;
                CSR_MCAUSE:        read_data_q <= mcause;
                CSR_MSCRATCH:      read_data_q <= mscratch_q;
                CSR_MCOUNTINHIBIT: read_data_q <= mcountinhibit_q;
                CSR_MIE:           read_data_q <= {16'b0, mie_q};
                CSR_MIP:           read_data_q <= {16'b0, mip};
                CSR_CYCLE,
                CSR_MCYCLE:        read_data_q <= cycle_cnt[31:0];
                CSR_CYCLEH,
                CSR_MCYCLEH:       read_data_q <= cycle_cnt[63:32];
                CSR_TIME:          read_data_q <= time_cnt[31:0];
                CSR_TIMEH:         read_data_q <= time_cnt[63:32];
                CSR_INSTRET,
                CSR_MINSTRET:      read_data_q <= instret_cnt[31:0];
                CSR_INSTRETH,
                CSR_MINSTRETH:     read_data_q <= instret_cnt[63:32];
                CSR_PMPCFG0: begin
                    read_data_q <= {PMP_TABLE[3].cfg, PMP_TABLE[2].cfg,
                                    PMP_TABLE[1].cfg, PMP_TABLE[0].cfg};
                end
                CSR_PMPCFG1: begin
                    read_data_q <= {PMP_TABLE[7].cfg, PMP_TABLE[6].cfg,
                                    PMP_TABLE[5].cfg, PMP_TABLE[4].cfg};
                end
                CSR_PMPCFG2:       read_data_q <= {24'b0, PMP_TABLE[8].cfg};
                CSR_PMPADDR0:      read_data_q <= PMP_TABLE[0].addr;
                CSR_PMPADDR1:      read_data_q <= PMP_TABLE[1].addr;
                CSR_PMPADDR2:      read_data_q <= PMP_TABLE[2].addr;
                CSR_PMPADDR3:      read_data_q <= PMP_TABLE[3].addr;
                CSR_PMPADDR4:      read_data_q <= PMP_TABLE[4].addr;
                CSR_PMPADDR5:      read_data_q <= PMP_TABLE[5].addr;
                CSR_PMPADDR6:      read_data_q <= PMP_TABLE[6].addr;
                CSR_PMPADDR7:      read_data_q <= PMP_TABLE[7].addr;
                CSR_PMPADDR8:      read_data_q <= PMP_TABLE[8].addr;
                default:           read_data_q <= '0;   // unimplemented address
            endcase
        end
    end

    assign read_data_o = read_data_q;

endmodule

// ==== verif/csr_file_tb.sv ====
`include "csr_cfg.svh"

module csr_file_tb;
    import csr_pkg::*;

    typedef enum {
        OP_WRITE,   // addr, data
        OP_READ,    // addr, exp_data
        OP_SNAP,    // read addr and keep the value
        OP_DELTA,   // read addr, expect kept value plus data
        OP_RETIRE,  // data retired pulses
        OP_IRQ,     // irq level from data[0]
        OP_TRAP,    // trap_pc from data, cause from exp_data
        OP_MRET,
        OP_JUMP,    // request from data[0], address from exp_data
        OP_ACCEPT
    } op_e;

    typedef struct packed {
        op_e       kind;
        csr_addr_e addr;
        word_t     data;
        word_t     exp_data;
    } step_t;

    localparam word_t     LFSR_SEED   = 32'h13e8;
    localparam word_t     LFSR_TAPS   = 32'h8020_0003;
    localparam int        NUM_RANDOM  = 200;
    localparam csr_addr_e UNUSED_ADDR = CSR_MISA;
    localparam word_t     REGION_END  = `CSR_PMP_REGION_SIZE;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       retired_i;
    logic       irq_i;
    trap_req_t  trap_i;
    logic       jmp_request_o;
    word_t      jmp_addr_o;
    logic       jmp_accept_i;
    csr_addr_e  read_addr_i;
    logic       read_enable_i;
    word_t      read_data_o;
    csr_wr_t    wr_i;
    word_t      lookup1_addr_i;
    logic [2:0] lookup1_rwx_o;
    word_t      lookup2_addr_i;
    logic [2:0] lookup2_rwx_o;

    step_t steps[$];
    word_t boundaries[$];
    word_t lfsr_state;
    word_t snap_value;
    logic  table_ready = 1'b0;

    csr_file dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .retired_i      (retired_i),
        .irq_i          (irq_i),
        .trap_i         (trap_i),
        .jmp_request_o  (jmp_request_o),
        .jmp_addr_o     (jmp_addr_o),
        .jmp_accept_i   (jmp_accept_i),
        .read_addr_i    (read_addr_i),
        .read_enable_i  (read_enable_i),
        .read_data_o    (read_data_o),
        .wr_i           (wr_i),
        .lookup1_addr_i (lookup1_addr_i),
        .lookup1_rwx_o  (lookup1_rwx_o),
        .lookup2_addr_i (lookup2_addr_i),
        .lookup2_rwx_o  (lookup2_rwx_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s = 0x%08h, expected 0x%08h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_rwx(string name, logic [2:0] got, logic [2:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s = %03b, expected %03b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_jump(logic exp_req, word_t exp_addr);
        if (jmp_request_o !== exp_req) begin
            stop_on_error($sformatf("** Error at %0t: jmp_request_o = %0b, expected %0b",
                                    $time, jmp_request_o, exp_req));
        end else if (exp_req) begin
            check_word("jmp_addr_o", jmp_addr_o, exp_addr);
        end
    endtask

    // galois lfsr, one step per bit
    function automatic logic random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic word_t random_bits(int n);
        word_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], random_bit()};
        end
        return value;
    endfunction

    // aim most addresses near a region so both sides of its end get hit
    function automatic word_t random_address();
        logic [1:0] sel;
        sel = random_bits(2);
        case (sel)
            2'd0:    return `CSR_PMP_RAM_BASE + random_bits(14);
            2'd1:    return `CSR_PMP_VRAM_BASE + random_bits(14);
            2'd2:    return 32'hFF00_0000 + random_bits(5);   // device words
            default: return random_bits(32);
        endcase
    endfunction

    // permissions as the memory map defines them
    function automatic logic [2:0] expected_rwx(word_t a);
        if (a >= `CSR_PMP_BIOS_BASE && a < `CSR_PMP_BIOS_BASE + REGION_END) begin
            return 3'b101;   // rx
        end
        if (a >= `CSR_PMP_RAM_BASE && a < `CSR_PMP_RAM_BASE + REGION_END) begin
            return 3'b011;
        end
        if (a >= `CSR_PMP_VRAM_BASE && a < `CSR_PMP_VRAM_BASE + REGION_END) begin
            return 3'b011;
        end
        if (a[31:2] == word_t'(`CSR_PMP_SEG_ADDR) >> 2) begin
            return 3'b011;
        end
        if (a[31:2] == word_t'(`CSR_PMP_SW_ADDR) >> 2) begin
            return 3'b001;   // switches are read only
        end
        return 3'b000;
    endfunction

    function automatic logic [7:0] cfg_byte(pmp_mode_e mode, logic [2:0] rwx);
        return {1'b1, 2'b00, mode, rwx};   // all entries locked
    endfunction

    function automatic void add_step(op_e kind, csr_addr_e addr, word_t data, word_t exp_data);
        step_t s;
        s.kind     = kind;
        s.addr     = addr;
        s.data     = data;
        s.exp_data = exp_data;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        // plain registers and constants
        add_step(OP_WRITE, CSR_MSCRATCH, 32'hDEAD_BEEF, '0);
        add_step(OP_READ,  CSR_MSCRATCH, '0, 32'hDEAD_BEEF);
        add_step(OP_WRITE, CSR_MTVEC, 32'h0000_2000, '0);
        add_step(OP_READ,  CSR_MTVEC, '0, 32'h0000_2000);
        add_step(OP_WRITE, CSR_MIE, 32'hFFFF_FFFF, '0);
        add_step(OP_READ,  CSR_MIE, '0, 32'h0000_0888);   // msi, mti, mei only
        add_step(OP_WRITE, CSR_MCOUNTINHIBIT, 32'h5, '0);
        add_step(OP_READ,  CSR_MCOUNTINHIBIT, '0, 32'h5);
        add_step(OP_READ,  CSR_MISA, '0, 32'h4000_0100);  // rv32i
        add_step(OP_READ,  CSR_MIMPID, '0, 32'h1);
        add_step(OP_READ,  CSR_MVENDORID, '0, '0);
        add_step(OP_READ,  CSR_MARCHID, '0, '0);
        add_step(OP_READ,  CSR_MHARTID, '0, '0);
        add_step(OP_READ,  csr_addr_e'(12'h7C0), '0, '0);
        add_step(OP_READ,  CSR_MSTATUS, '0, '0);
        add_step(OP_READ,  CSR_MIP, '0, '0);

        // counters and inhibit
        add_step(OP_WRITE,  CSR_MCOUNTINHIBIT, 32'h4, '0);
        add_step(OP_SNAP,   CSR_INSTRET, '0, '0);
        add_step(OP_RETIRE, UNUSED_ADDR, 32'd6, '0);
        add_step(OP_DELTA,  CSR_INSTRET, 32'd0, '0);
        add_step(OP_WRITE,  CSR_MCOUNTINHIBIT, 32'h0, '0);
        add_step(OP_SNAP,   CSR_MINSTRET, '0, '0);
        add_step(OP_RETIRE, UNUSED_ADDR, 32'd3, '0);
        add_step(OP_DELTA,  CSR_MINSTRET, 32'd3, '0);
        add_step(OP_WRITE,  CSR_MCOUNTINHIBIT, 32'h1, '0);
        add_step(OP_SNAP,   CSR_CYCLE, '0, '0);
        add_step(OP_RETIRE, UNUSED_ADDR, 32'd4, '0);
        add_step(OP_DELTA,  CSR_CYCLE, 32'd0, '0);
        add_step(OP_WRITE,  CSR_CYCLE, 32'h1234_5678, '0);
        add_step(OP_READ,   CSR_CYCLE, '0, 32'h1234_5678);
        add_step(OP_READ,   CSR_MCYCLE, '0, 32'h1234_5678);

        // synchronous trap, direct mode
        add_step(OP_WRITE,  CSR_MSTATUS, 32'h8, '0);
        add_step(OP_READ,   CSR_MSTATUS, '0, 32'h8);
        add_step(OP_TRAP,   UNUSED_ADDR, 32'h0000_0100, 32'h2);
        add_step(OP_JUMP,   UNUSED_ADDR, 32'h1, 32'h0000_2000);
        add_step(OP_ACCEPT, UNUSED_ADDR, '0, '0);
        add_step(OP_JUMP,   UNUSED_ADDR, 32'h0, '0);
        add_step(OP_READ,   CSR_MEPC, '0, 32'h0000_0100);
        add_step(OP_READ,   CSR_MCAUSE, '0, 32'h2);
        add_step(OP_READ,   CSR_MSTATUS, '0, 32'h80);    // mpie holds old mie

        // return from trap
        add_step(OP_MRET,   UNUSED_ADDR, '0, '0);
        add_step(OP_JUMP,   UNUSED_ADDR, 32'h1, 32'h0000_0100);
        add_step(OP_ACCEPT, UNUSED_ADDR, '0, '0);
        add_step(OP_JUMP,   UNUSED_ADDR, 32'h0, '0);
        add_step(OP_READ,   CSR_MSTATUS, '0, 32'h88);
        add_step(OP_READ,   CSR_MEPC, '0, '0);
        add_step(OP_READ,   CSR_MCAUSE, '0, '0);

        // external interrupt, vectored mode
        add_step(OP_WRITE,  CSR_MTVEC, 32'h0000_3001, '0);
        add_step(OP_READ,   CSR_MTVEC, '0, 32'h0000_3001);
        add_step(OP_IRQ,    UNUSED_ADDR, 32'h1, '0);
        add_step(OP_JUMP,   UNUSED_ADDR, 32'h1, 32'h0000_302C);   // base + 4 * 11
        add_step(OP_READ,   CSR_MIP, '0, 32'h0000_0800);
        add_step(OP_ACCEPT, UNUSED_ADDR, '0, '0);
        add_step(OP_JUMP,   UNUSED_ADDR, 32'h0, '0);
        add_step(OP_READ,   CSR_MCAUSE, '0, 32'h8000_000B);
        add_step(OP_READ,   CSR_MSTATUS, '0, 32'h80);
        add_step(OP_IRQ,    UNUSED_ADDR, 32'h0, '0);

        // fixed pmp table
        add_step(OP_READ, CSR_PMPCFG0, '0, {cfg_byte(PMP_OFF, 3'b000), cfg_byte(PMP_NAPOT, 3'b011),
                                            cfg_byte(PMP_OFF, 3'b000), cfg_byte(PMP_NAPOT, 3'b101)});
        add_step(OP_READ, CSR_PMPCFG1, '0, {cfg_byte(PMP_NA4, 3'b001), cfg_byte(PMP_NA4, 3'b011),
                                            cfg_byte(PMP_OFF, 3'b000), cfg_byte(PMP_NAPOT, 3'b011)});
        add_step(OP_READ, CSR_PMPCFG2, '0, {24'b0, cfg_byte(PMP_TOR, 3'b000)});
        add_step(OP_READ, CSR_PMPADDR0, '0, word_t'(`CSR_PMP_BIOS_BASE) >> 2);
        add_step(OP_READ, CSR_PMPADDR1, '0, (`CSR_PMP_BIOS_BASE + REGION_END) >> 2);
        add_step(OP_READ, CSR_PMPADDR2, '0, word_t'(`CSR_PMP_RAM_BASE) >> 2);
        add_step(OP_READ, CSR_PMPADDR3, '0, (`CSR_PMP_RAM_BASE + REGION_END) >> 2);
        add_step(OP_READ, CSR_PMPADDR4, '0, word_t'(`CSR_PMP_VRAM_BASE) >> 2);
        add_step(OP_READ, CSR_PMPADDR5, '0, (`CSR_PMP_VRAM_BASE + REGION_END) >> 2);
        add_step(OP_READ, CSR_PMPADDR6, '0, word_t'(`CSR_PMP_SEG_ADDR) >> 2);
        add_step(OP_READ, CSR_PMPADDR7, '0, word_t'(`CSR_PMP_SW_ADDR) >> 2);
        add_step(OP_READ, CSR_PMPADDR8, '0, 32'h3FFF_FFFF);
    endfunction

    function automatic void build_boundaries();
        word_t bases[3];
        bases[0] = `CSR_PMP_BIOS_BASE;
        bases[1] = `CSR_PMP_RAM_BASE;
        bases[2] = `CSR_PMP_VRAM_BASE;
        foreach (bases[i]) begin
            boundaries.push_back(bases[i]);
            boundaries.push_back(bases[i] - 4);
            boundaries.push_back(bases[i] + REGION_END - 4);
            boundaries.push_back(bases[i] + REGION_END);
        end
        boundaries.push_back(`CSR_PMP_SEG_ADDR);
        boundaries.push_back(`CSR_PMP_SEG_ADDR - 4);
        boundaries.push_back(`CSR_PMP_SEG_ADDR + 3);
        boundaries.push_back(`CSR_PMP_SW_ADDR);
        boundaries.push_back(`CSR_PMP_SW_ADDR + 4);
        boundaries.push_back(32'hFFFF_FFFC);
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #5;
    endtask

    task automatic read_csr(csr_addr_e addr, output word_t value);
        read_addr_i   = addr;
        read_enable_i = 1'b1;
        next_cycle();
        value         = read_data_o;   // registered, one cycle later
        read_enable_i = 1'b0;
    endtask

    task automatic run_step(step_t s);
        word_t got;
        case (s.kind)
            OP_WRITE: begin
                wr_i = '{addr: s.addr, data: s.data, en: 1'b1};
                next_cycle();
                wr_i.en = 1'b0;
            end
            OP_READ: begin
                read_csr(s.addr, got);
                check_word($sformatf("read_data_o[%s]", s.addr.name()), got, s.exp_data);
            end
            OP_SNAP: begin
                read_csr(s.addr, snap_value);
            end
            OP_DELTA: begin
                read_csr(s.addr, got);
                check_word($sformatf("read_data_o[%s]", s.addr.name()), got,
                           snap_value + s.data);
            end
            OP_RETIRE: begin
                retired_i = 1'b1;
                repeat (s.data) next_cycle();
                retired_i = 1'b0;
            end
            OP_IRQ: irq_i = s.data[0];   // level only, no clock
            OP_TRAP: begin
                trap_i.trap_pc = s.data;
                trap_i.cause   = mcause_t'(s.exp_data);
                trap_i.mtrap   = 1'b1;
            end
            OP_MRET: trap_i.mret = 1'b1;
            OP_JUMP: begin
                #10;   // same cycle as the request inputs
                check_jump(s.data[0], s.exp_data);
                next_cycle();
            end
            OP_ACCEPT: begin
                jmp_accept_i = 1'b1;
                next_cycle();
                jmp_accept_i = 1'b0;
                trap_i.mtrap = 1'b0;   // pipeline drops the request
                trap_i.mret  = 1'b0;
            end
            default: stop_on_error("unknown operation in the stimulus table");
        endcase
    endtask

    task automatic check_lookup(word_t addr);
        lookup1_addr_i = addr;
        lookup2_addr_i = addr + 4;   // next word on the second port
        #10;
        check_rwx($sformatf("lookup1_rwx_o @%08h", addr), lookup1_rwx_o, expected_rwx(addr));
        check_rwx($sformatf("lookup2_rwx_o @%08h", addr + 4), lookup2_rwx_o,
                  expected_rwx(addr + 4));
        next_cycle();
    endtask

    initial begin
        wait (table_ready);
        repeat (2 + steps.size() * 20 + NUM_RANDOM + boundaries.size()) @(posedge clk_i);
        stop_on_error("timeout, the test sequence did not finish in time");
    end

    initial begin
        reset_i        = 1'b1;
        retired_i      = 1'b0;
        irq_i          = 1'b0;
        trap_i         = '0;
        jmp_accept_i   = 1'b0;
        read_addr_i    = CSR_MISA;
        read_enable_i  = 1'b0;
        wr_i           = '0;
        lookup1_addr_i = '0;
        lookup2_addr_i = '0;
        lfsr_state     = LFSR_SEED;
        build_table();
        build_boundaries();
        table_ready = 1'b1;

        repeat (2) @(posedge clk_i);
        #5;
        reset_i = 1'b0;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        foreach (boundaries[i]) begin
            check_lookup(boundaries[i]);
        end
        repeat (NUM_RANDOM) begin
            check_lookup(random_address());
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
hw/csr_pkg.sv
hw/csr_pmp_lookup.sv
hw/csr_counters.sv
hw/csr_trap_ctrl.sv
hw/csr_file.sv
verif/csr_file_tb.sv
